// ==== hdl/ppuBusPkg.sv ====
package ppuBusPkg;

   localparam int CpuAddrWidth = 16;
   localparam int DataWidth = 8;
   localparam int VramAddrWidth = 13;                    // Offset from VramBase.

   // CPU window onto the external VRAM.
   localparam logic [CpuAddrWidth-1:0] VramBase = 16'h8000;
   localparam logic [CpuAddrWidth-1:0] VramLast = 16'h9FFF;

   localparam logic [CpuAddrWidth-1:0] RegLcdc = 16'hFF40;
   localparam logic [CpuAddrWidth-1:0] RegStat = 16'hFF41;
   localparam logic [CpuAddrWidth-1:0] RegLy = 16'hFF44;   // Read only.
   localparam logic [CpuAddrWidth-1:0] RegLyc = 16'hFF45;
   localparam logic [CpuAddrWidth-1:0] RegBgp = 16'hFF47;

   // Background tile maps, 32x32 entries each.
   localparam logic [VramAddrWidth-1:0] MapBase0 = 13'h1800;
   localparam logic [VramAddrWidth-1:0] MapBase1 = 13'h1C00;

   localparam logic [VramAddrWidth-1:0] TileBaseUnsigned = 13'h0000;
   localparam logic [VramAddrWidth-1:0] TileBaseSigned = 13'h0800;  // Index offset by 8'h80.

   localparam logic [DataWidth-1:0] LockedData = 8'hFF;   // VRAM read while mode 3 owns the port.

endpackage

// ==== hdl/ppuVideoPkg.sv ====
package ppuVideoPkg;

   localparam int ScreenWidth = 160;
   localparam int TileCount = 20;                        // Tiles per visible line.
   localparam int DotsPerLine = 456;
   localparam int OamScanEnd = 80;
   localparam int TransferEnd = 252;

   typedef enum logic [1:0] {
      HBlank   = 2'd0,
      VBlank   = 2'd1,
      OamScan  = 2'd2,
      Transfer = 2'd3
   } lcdMode_e;

   typedef struct packed {
      logic       displayOn;
      logic [1:0] reservedHigh;                          // Window and sprite bits, unused here.
      logic       tileDataUnsigned;
      logic       mapSelect;
      logic [2:0] reservedLow;
   } lcdcFields_t;

   typedef union packed {
      logic [7:0]  raw;
      lcdcFields_t fields;
   } lcdc_u;

   typedef logic [3:0][1:0] bgPalette_t;                 // Shade per colour number.

   typedef logic [ScreenWidth-1:0] linePlane_t;

   function automatic logic [1:0] tileColour(logic [7:0] low, logic [7:0] high, int pixel);
      return {high[7 - pixel], low[7 - pixel]};          // Leftmost pixel is bit 7.
   endfunction

   function automatic logic [1:0] paletteShade(bgPalette_t palette, logic [1:0] colour);
      return palette[colour];
   endfunction

endpackage

// ==== hdl/vramIf.sv ====
`timescale 1ns/1ps

interface vramIf #(
   parameter int AddrWidth = 13,
   parameter int DataWidth = 8
) ();

   logic                 req;                            // Renderer owns the port.
   logic [AddrWidth-1:0] addr;
   logic                 rd;
   logic [DataWidth-1:0] data;

   modport fetcher (output req, output addr, output rd, input data);
   modport arbiter (input req, input addr, input rd, output data);

endinterface

// ==== hdl/ppuCtrlIf.sv ====
`timescale 1ns/1ps

interface ppuCtrlIf import ppuBusPkg::*, ppuVideoPkg::*; ();

   lcdc_u                lcdc;
   logic [3:0]           statEnable;                     // LYC, mode 2, mode 1, mode 0.
   logic [DataWidth-1:0] lyc;
   bgPalette_t           bgp;
   logic [DataWidth-1:0] ly;
   lcdMode_e             mode;

   modport regs (output lcdc, output statEnable, output lyc, output bgp, input ly, input mode);
   modport timing (input lcdc, input statEnable, input lyc, output ly, output mode);
   modport fetcher (input lcdc, input ly, input mode);
   modport composer (input bgp, input ly, input mode);

endinterface

// ==== hdl/cpuBusInterface.sv ====
`timescale 1ns/1ps

module cpuBusInterface import ppuBusPkg::*, ppuVideoPkg::*; (
   input  logic                     clock,
   input  logic                     arstN,
   input  logic [CpuAddrWidth-1:0]  cpuAddr,
   input  logic [DataWidth-1:0]     cpuWriteData,
   input  logic                     cpuSelect,
   input  logic                     cpuWrite,
   input  logic                     cpuRead,
   output logic [DataWidth-1:0]     cpuReadData,
   ppuCtrlIf.regs                   ctrl,
   vramIf.arbiter                   vram,
   output logic [VramAddrWidth-1:0] vramAddr,
   output logic [DataWidth-1:0]     vramWriteData,
   input  logic [DataWidth-1:0]     vramReadData,
   output logic                     vramWrite,
   output logic                     vramRead
);

   lcdc_u                   lcdcReg;
   logic [3:0]              statEnableReg;
   logic [DataWidth-1:0]    lycReg;
   bgPalette_t              bgpReg;
   logic                    regWrite;
   logic                    vramHit;
   logic                    lycMatch;
   logic                    readPending;
   logic                    readLocked;
   logic [CpuAddrWidth-1:0] vramOffset;

   assign regWrite = cpuSelect && cpuWrite;
   assign vramHit = cpuSelect && (cpuAddr >= VramBase) && (cpuAddr <= VramLast);
   assign vramOffset = cpuAddr - VramBase;
   assign lycMatch = (ctrl.ly == lycReg);

   always_ff @(posedge clock or negedge arstN) begin
      if (!arstN) begin
         lcdcReg.raw <= '0;
         statEnableReg <= '0;
         lycReg <= '0;
         bgpReg <= '0;
      end else if (regWrite) begin
         unique case (cpuAddr)
            RegLcdc: lcdcReg.raw <= cpuWriteData;
            RegStat: statEnableReg <= cpuWriteData[6:3];  // Low bits are status only.
            RegLyc:  lycReg <= cpuWriteData;
            RegBgp:  bgpReg <= cpuWriteData;
            default: ;
         endcase
      end
   end

   // Synchronous VRAM answers one cycle after the strobe.
   always_ff @(posedge clock or negedge arstN) begin
      if (!arstN) begin
         readPending <= 1'b0;
         readLocked <= 1'b0;
      end else begin
         readPending <= vramHit && cpuRead;
         readLocked <= vram.req;
      end
   end

   always_comb begin
      cpuReadData = '1;                                  // Unmapped and dropped registers.
      if (readPending) begin
         cpuReadData = readLocked ? LockedData : vramReadData;
      end else begin
         unique case (cpuAddr)
            RegLcdc: cpuReadData = lcdcReg.raw;
            RegStat: cpuReadData = {1'b1, statEnableReg, lycMatch, ctrl.mode};
            RegLy:   cpuReadData = ctrl.ly;
            RegLyc:  cpuReadData = lycReg;
            RegBgp:  cpuReadData = bgpReg;
            default: ;
         endcase
      end
   end

   assign vramAddr = vram.req ? vram.addr : vramOffset[VramAddrWidth-1:0];
   assign vramRead = vram.req ? vram.rd : (vramHit && cpuRead);
   assign vramWrite = !vram.req && vramHit && cpuWrite;   // CPU writes dropped in mode 3.
   assign vramWriteData = cpuWriteData;
   assign vram.data = vramReadData;

   assign ctrl.lcdc = lcdcReg;
   assign ctrl.statEnable = statEnableReg;
   assign ctrl.lyc = lycReg;
   assign ctrl.bgp = bgpReg;

endmodule

// ==== hdl/lcdTiming.sv ====
`timescale 1ns/1ps

module lcdTiming import ppuBusPkg::*, ppuVideoPkg::*; #(
   parameter int VisibleLines = 144,
   parameter int LinesPerFrame = 154
) (
   input  logic     clock,
   input  logic     arstN,
   ppuCtrlIf.timing ctrl,
   output logic     vblankIrq,
   output logic     statIrq
);

   logic [8:0]           dotCount;
   logic [DataWidth-1:0] lyCount;
   lcdMode_e             mode;

   always_ff @(posedge clock or negedge arstN) begin
      if (!arstN) begin
         dotCount <= '0;
         lyCount <= '0;
      end else if (ctrl.lcdc.fields.displayOn) begin
         if (dotCount == DotsPerLine - 1) begin
            dotCount <= '0;
            if (lyCount == LinesPerFrame - 1) begin
               lyCount <= '0;
            end else begin
               lyCount <= lyCount + 1'b1;
            end
         end else begin
            dotCount <= dotCount + 1'b1;
         end
      end
   end

   always_comb begin
      if (!ctrl.lcdc.fields.displayOn) begin
         mode = HBlank;
      end else if (lyCount >= VisibleLines) begin
         mode = VBlank;
      end else if (dotCount < OamScanEnd) begin
         mode = OamScan;
      end else if (dotCount < TransferEnd) begin
         mode = Transfer;
      end else begin
         mode = HBlank;
      end
   end

   always_ff @(posedge clock or negedge arstN) begin
      if (!arstN) begin
         vblankIrq <= 1'b0;
      end else if (mode == VBlank) begin
         vblankIrq <= 1'b1;
      end else if (mode == OamScan) begin
         vblankIrq <= 1'b0;                              // Cleared as line 0 starts its OAM scan.
      end
   end

   assign statIrq = (ctrl.statEnable[3] && (lyCount == ctrl.lyc))
                 || (ctrl.statEnable[2] && (mode == OamScan))
                 || (ctrl.statEnable[1] && (mode == VBlank))
                 || (ctrl.statEnable[0] && (mode == HBlank));

   assign ctrl.ly = lyCount;
   assign ctrl.mode = mode;

endmodule

// ==== hdl/bgTileFetcher.sv ====
`timescale 1ns/1ps

module bgTileFetcher import ppuBusPkg::*, ppuVideoPkg::*; (
   input  logic                 clock,
   input  logic                 arstN,
   ppuCtrlIf.fetcher            ctrl,
   vramIf.fetcher               vram,
   output logic                 tileValid,
   output logic [4:0]           tileIndex,
   output logic [DataWidth-1:0] tileLow,
   output logic [DataWidth-1:0] tileHigh
);

   logic                     active;
   logic [2:0]               step;
   logic [4:0]               tileCount;                  // Runs one past TileCount when done.
   logic [DataWidth-1:0]     tileNum;
   logic [DataWidth-1:0]     rowTile;
   logic [DataWidth-1:0]     rowIndex;
   logic [VramAddrWidth-1:0] tileBase;
   logic [VramAddrWidth-1:0] mapAddr;
   logic [VramAddrWidth-1:0] rowAddr;
   logic [VramAddrWidth-1:0] addrReg;
   logic                     rdReg;

   assign active = (ctrl.mode == Transfer);

   always_comb begin
      mapAddr = (ctrl.lcdc.fields.mapSelect ? MapBase1 : MapBase0)
              + {3'b0, ctrl.ly[7:3], 5'b0} + {8'b0, tileCount};
      rowTile = (step == 3'd2) ? vram.data : tileNum;
      if (ctrl.lcdc.fields.tileDataUnsigned) begin
         rowIndex = rowTile;
         tileBase = TileBaseUnsigned;
      end else begin
         rowIndex = rowTile + 8'h80;
         tileBase = TileBaseSigned;
      end
      rowAddr = tileBase + {1'b0, rowIndex, 4'b0} + {9'b0, ctrl.ly[2:0], step == 3'd4};
   end

   // Tile t issues its map read at step 0; its high byte arrives at step 0 of tile t+1.
   always_ff @(posedge clock or negedge arstN) begin
      if (!arstN) begin
         step <= '0;
         tileCount <= '0;
         addrReg <= '0;
         rdReg <= 1'b0;
         tileValid <= 1'b0;
         tileIndex <= '0;
      end else if (!active) begin
         step <= '0;
         tileCount <= '0;
         rdReg <= 1'b0;
         tileValid <= 1'b0;
      end else begin
         tileValid <= 1'b0;
         rdReg <= 1'b0;
         unique case (step)
            3'd0: begin
               if ((tileCount != 0) && (tileCount <= TileCount)) begin
                  tileValid <= 1'b1;
                  tileIndex <= tileCount - 1'b1;
               end
               if (tileCount < TileCount) begin
                  addrReg <= mapAddr;
                  rdReg <= 1'b1;
                  step <= 3'd1;
               end else if (tileCount == TileCount) begin
                  tileCount <= tileCount + 1'b1;
               end
            end
            3'd2, 3'd4: begin
               addrReg <= rowAddr;
               rdReg <= 1'b1;
               step <= step + 1'b1;
            end
            3'd5: begin
               step <= '0;
               tileCount <= tileCount + 1'b1;
            end
            default: step <= step + 1'b1;
         endcase
      end
   end

   always_ff @(posedge clock) begin
      if (active) begin
         if (step == 3'd2) begin
            tileNum <= vram.data;
         end
         if (step == 3'd4) begin
            tileLow <= vram.data;
         end
         if (step == 3'd0) begin
            tileHigh <= vram.data;                       // Paired with tileValid.
         end
      end
   end

   assign vram.req = active;
   assign vram.addr = addrReg;
   assign vram.rd = rdReg;

endmodule

// ==== hdl/lineComposer.sv ====
`timescale 1ns/1ps

module lineComposer import ppuBusPkg::*, ppuVideoPkg::*; #(
   parameter int VisibleLines = 144
) (
   input  logic                 clock,
   input  logic                 arstN,
   ppuCtrlIf.composer           ctrl,
   input  logic                 tileValid,
   input  logic [4:0]           tileIndex,
   input  logic [DataWidth-1:0] tileLow,
   input  logic [DataWidth-1:0] tileHigh,
   output linePlane_t           linePlane0,
   output linePlane_t           linePlane1,
   output logic                 lineReady
);

   lcdMode_e   prevMode;
   logic [7:0] shadeLow;
   logic [7:0] shadeHigh;
   logic       oamEntry;

   always_comb begin
      logic [1:0] shade;
      for (int i = 0; i < 8; i++) begin
         shade = paletteShade(ctrl.bgp, tileColour(tileLow, tileHigh, i));
         shadeLow[i] = shade[0];
         shadeHigh[i] = shade[1];
      end
   end

   always_ff @(posedge clock or negedge arstN) begin
      if (!arstN) begin
         prevMode <= HBlank;
      end else begin
         prevMode <= ctrl.mode;
      end
   end

   assign oamEntry = (ctrl.mode == OamScan) && (prevMode != OamScan);
   assign lineReady = (ctrl.mode == HBlank) && (prevMode == Transfer)
                   && (ctrl.ly < VisibleLines);          // First HBlank cycle only.

   always_ff @(posedge clock) begin
      if (oamEntry) begin
         linePlane0 <= '0;
         linePlane1 <= '0;
      end else if (tileValid) begin
         linePlane0[8 * tileIndex +: 8] <= shadeLow;
         linePlane1[8 * tileIndex +: 8] <= shadeHigh;
      end
   end

endmodule

// ==== hdl/ppuTop.sv ====
`timescale 1ns/1ps

module ppuTop import ppuBusPkg::*, ppuVideoPkg::*; #(
   parameter int VisibleLines = 144,
   parameter int LinesPerFrame = 154
) (
   input  logic                     clock,
   input  logic                     arstN,
   input  logic [CpuAddrWidth-1:0]  cpuAddr,
   input  logic [DataWidth-1:0]     cpuWriteData,
   input  logic                     cpuSelect,
   input  logic                     cpuWrite,
   input  logic                     cpuRead,
   output logic [DataWidth-1:0]     cpuReadData,
   output logic [VramAddrWidth-1:0] vramAddr,
   output logic [DataWidth-1:0]     vramWriteData,
   input  logic [DataWidth-1:0]     vramReadData,
   output logic                     vramWrite,
   output logic                     vramRead,
   output logic                     vblankIrq,
   output logic                     statIrq,
   output logic [DataWidth-1:0]     ly,
   output linePlane_t               linePlane0,
   output linePlane_t               linePlane1,
   output logic                     lineReady
);

   logic                 tileValid;
   logic [4:0]           tileIndex;
   logic [DataWidth-1:0] tileLow;
   logic [DataWidth-1:0] tileHigh;

   vramIf #(.AddrWidth(VramAddrWidth), .DataWidth(DataWidth)) vramBus ();
   ppuCtrlIf ctrlBus ();

   assign ly = ctrlBus.ly;

   cpuBusInterface u_cpuBus (
      .clock, .arstN, .cpuAddr, .cpuWriteData, .cpuSelect, .cpuWrite, .cpuRead, .cpuReadData,
      .ctrl(ctrlBus), .vram(vramBus),
      .vramAddr, .vramWriteData, .vramReadData, .vramWrite, .vramRead
   );

   lcdTiming #(.VisibleLines(VisibleLines), .LinesPerFrame(LinesPerFrame)) u_timing (
      .clock, .arstN, .ctrl(ctrlBus), .vblankIrq, .statIrq
   );

   bgTileFetcher u_fetcher (
      .clock, .arstN, .ctrl(ctrlBus), .vram(vramBus), .tileValid, .tileIndex, .tileLow, .tileHigh
   );

   lineComposer #(.VisibleLines(VisibleLines)) u_composer (
      .clock, .arstN, .ctrl(ctrlBus), .tileValid, .tileIndex, .tileLow, .tileHigh,
      .linePlane0, .linePlane1, .lineReady
   );

endmodule

// ==== verification/tbPpu.sv ====
`timescale 1ns/1ps

module tbPpu import ppuBusPkg::*; ();

   localparam int VisibleLines = 8;
   localparam int LinesPerFrame = 10;
   localparam int FrameCycles = LinesPerFrame * 456;
   localparam int CycleLimit = 7 * FrameCycles + 2000;
   localparam logic [1:0] ModeHBlank = 2'd0;
   localparam logic [1:0] ModeVBlank = 2'd1;
   localparam logic [1:0] ModeOamScan = 2'd2;
   localparam logic [1:0] ModeTransfer = 2'd3;

   logic         clock;
   logic         arstN;
   logic [15:0]  cpuAddr;
   logic [7:0]   cpuWriteData;
   logic         cpuSelect;
   logic         cpuWrite;
   logic         cpuRead;
   logic [7:0]   cpuReadData;
   logic [12:0]  vramAddr;
   logic [7:0]   vramWriteData;
   logic [7:0]   vramReadData;
   logic         vramWrite;
   logic         vramRead;
   logic         vblankIrq;
   logic         statIrq;
   logic [7:0]   ly;
   logic [159:0] linePlane0;
   logic [159:0] linePlane1;
   logic         lineReady;

   logic [7:0]   vram [0:8191];
   logic [31:0]  lfsr;
   int           cycles = 0;
   int           linesSeen;
   logic         checking;

   // Reference model state.
   int           mDot;
   logic [7:0]   mLy;
   logic         mVblank;
   logic         mPending;                               // CPU VRAM read strobed last edge.
   logic [7:0]   mLcdc;
   logic [3:0]   mStatEn;
   logic [7:0]   mLyc;
   logic [7:0]   mBgp;

   ppuTop #(.VisibleLines(VisibleLines), .LinesPerFrame(LinesPerFrame)) u_dut (
      .clock, .arstN, .cpuAddr, .cpuWriteData, .cpuSelect, .cpuWrite, .cpuRead, .cpuReadData,
      .vramAddr, .vramWriteData, .vramReadData, .vramWrite, .vramRead,
      .vblankIrq, .statIrq, .ly, .linePlane0, .linePlane1, .lineReady
   );

   initial begin
      clock = 1'b0;
      forever #4 clock = ~clock;
   end

   // Synchronous VRAM, data one cycle after the read strobe.
   always @(posedge clock) begin
      if (vramWrite) vram[vramAddr] <= vramWriteData;
      if (vramRead) vramReadData <= #1 vram[vramAddr];
   end

   always @(posedge clock) begin
      cycles <= cycles + 1;
      if (cycles >= CycleLimit) begin
         $display("Timeout after %0d cycles, the tests did not finish", cycles);
         $display("TEST FAIL");
         $fatal(1, "Simulation timed out");
      end
   end

   task automatic checkValue(string name, logic [159:0] expected, logic [159:0] actual);
      if (actual !== expected) begin
         $display("FAIL %s expected %0h actual %0h", name, expected, actual);
         $display("TEST FAIL");
         $fatal(1, "Check %s failed", name);
      end
   endtask

   // Galois LFSR, one step per bit taken.
   function automatic logic [31:0] randBits(int count);
      logic [31:0] value;
      value = '0;
      for (int i = 0; i < count; i++) begin
         value = {value[30:0], lfsr[0]};
         lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0);
      end
      return value;
   endfunction

   function automatic logic [1:0] modelMode();
      if (!mLcdc[7]) return ModeHBlank;
      if (mLy >= VisibleLines) return ModeVBlank;
      if (mDot < 80) return ModeOamScan;
      if (mDot < 252) return ModeTransfer;
      return ModeHBlank;
   endfunction

   function automatic logic expectStatIrq();
      logic [1:0] mode;
      mode = modelMode();
      return (mStatEn[3] && (mLy == mLyc)) || (mStatEn[2] && (mode == ModeOamScan))
          || (mStatEn[1] && (mode == ModeVBlank)) || (mStatEn[0] && (mode == ModeHBlank));
   endfunction

   function automatic logic expectLineReady();
      return mLcdc[7] && (mLy < VisibleLines) && (mDot == 252);
   endfunction

   // One background line from the testbench VRAM, BGP and LCDC copies.
   function automatic logic [159:0] expectLine(int planeSel);
      logic [159:0] line;
      logic [12:0]  mapAddr;
      logic [12:0]  rowAddr;
      logic [7:0]   tileNum;
      logic [7:0]   low;
      logic [7:0]   high;
      logic [1:0]   colour;
      logic [1:0]   shade;
      line = '0;
      for (int t = 0; t < 20; t++) begin
         mapAddr = (mLcdc[3] ? 13'h1C00 : 13'h1800) + 32 * (mLy / 8) + t;
         tileNum = vram[mapAddr];
         if (mLcdc[4]) rowAddr = 16 * tileNum;
         else rowAddr = 13'h0800 + 16 * 8'(tileNum + 8'h80);
         rowAddr = rowAddr + 2 * (mLy % 8);
         low = vram[rowAddr];
         high = vram[rowAddr + 13'd1];
         for (int i = 0; i < 8; i++) begin
            colour = {high[7 - i], low[7 - i]};
            shade = mBgp[2 * colour +: 2];
            line[8 * t + i] = shade[planeSel];
         end
      end
      return line;
   endfunction

   task automatic modelEdge();
      logic [1:0] mode;
      mode = modelMode();
      if (mode == ModeVBlank) mVblank = 1'b1;
      else if (mode == ModeOamScan) mVblank = 1'b0;
      if (mLcdc[7]) begin
         if (mDot == 455) begin
            mDot = 0;
            mLy = (mLy == LinesPerFrame - 1) ? 8'd0 : mLy + 8'd1;
         end else begin
            mDot++;
         end
      end
      mPending = cpuSelect && cpuRead && (cpuAddr >= VramBase) && (cpuAddr <= VramLast);
      if (cpuSelect && cpuWrite) begin
         case (cpuAddr)
            RegLcdc: mLcdc = cpuWriteData;
            RegStat: mStatEn = cpuWriteData[6:3];
            RegLyc:  mLyc = cpuWriteData;
            RegBgp:  mBgp = cpuWriteData;
            default: ;
         endcase
      end
   endtask

   task automatic tick();
      @(posedge clock);
      modelEdge();
      #1;                                                // Inputs change here.
   endtask

   task automatic idle(int count);
      repeat (count) tick();
   endtask

   task automatic waitMode(logic [1:0] mode);
      while (modelMode() != mode) tick();
   endtask

   task automatic busWrite(logic [15:0] addr, logic [7:0] data);
      cpuSelect = 1'b1;
      cpuWrite = 1'b1;
      cpuRead = 1'b0;
      cpuAddr = addr;
      cpuWriteData = data;
      tick();
      cpuSelect = 1'b0;
      cpuWrite = 1'b0;
      cpuAddr = RegStat;
   endtask

   task automatic readCheck(string name, logic [15:0] addr, logic [7:0] expected);
      cpuSelect = 1'b1;
      cpuRead = 1'b1;
      cpuAddr = addr;
      #1;
      checkValue(name, expected, cpuReadData);
      tick();
      cpuSelect = 1'b0;
      cpuRead = 1'b0;
      cpuAddr = RegStat;
   endtask

   task automatic vramReadCheck(string name, logic [15:0] addr, logic [7:0] expected);
      cpuSelect = 1'b1;
      cpuRead = 1'b1;
      cpuAddr = addr;
      tick();
      cpuSelect = 1'b0;
      cpuRead = 1'b0;
      cpuAddr = RegStat;
      #1;
      checkValue(name, expected, cpuReadData);
      tick();
   endtask

   // Every cycle: timing, interrupts, STAT and finished lines.
   always @(negedge clock) begin
      if (checking) begin
         checkValue("ly", mLy, ly);
         checkValue("vblankIrq", mVblank, vblankIrq);
         checkValue("statIrq", expectStatIrq(), statIrq);
         checkValue("lineReady", expectLineReady(), lineReady);
         if ((cpuAddr == RegStat) && !mPending) begin
            checkValue("stat", {1'b1, mStatEn, mLy == mLyc, modelMode()}, cpuReadData);
         end
         if ((modelMode() == ModeOamScan) && (mDot != 0)) begin
            checkValue("linePlane0 clear", 160'h0, linePlane0);
            checkValue("linePlane1 clear", 160'h0, linePlane1);
         end
         if (lineReady) begin
            checkValue("linePlane0", expectLine(0), linePlane0);
            checkValue("linePlane1", expectLine(1), linePlane1);
            linesSeen++;
         end
      end
   end

   initial begin
      logic [15:0] addr;
      logic [7:0]  data;
      logic [7:0]  old;
      lfsr = 32'hdc60e134;
      arstN = 1'b0;
      cpuAddr = RegStat;
      cpuWriteData = '0;
      cpuSelect = 1'b0;
      cpuWrite = 1'b0;
      cpuRead = 1'b0;
      vramReadData = '0;
      checking = 1'b0;
      linesSeen = 0;
      mDot = 0;
      mLy = '0;
      mVblank = 1'b0;
      mPending = 1'b0;
      mLcdc = '0;
      mStatEn = '0;
      mLyc = '0;
      mBgp = '0;
      for (int a = 0; a < 8192; a++) vram[a] = 8'(a) ^ 8'(a >> 5) ^ 8'(a >> 10);

      repeat (10) @(posedge clock);
      #1;
      arstN = 1'b1;
      checking = 1'b1;
      #1;
      checkValue("reset ly", 0, ly);
      checkValue("reset vblankIrq", 0, vblankIrq);
      checkValue("reset lineReady", 0, lineReady);
      checkValue("reset vramWrite", 0, vramWrite);
      checkValue("reset vramRead", 0, vramRead);
      tick();

      // Registers with the display off.
      busWrite(RegLcdc, 8'(randBits(7)));
      busWrite(RegLyc, 8'(randBits(8)));
      busWrite(RegBgp, 8'(randBits(8)));
      busWrite(RegStat, 8'(randBits(8)));
      readCheck("lcdc", RegLcdc, mLcdc);
      readCheck("lyc", RegLyc, mLyc);
      readCheck("bgp", RegBgp, mBgp);
      readCheck("stat", RegStat, {1'b1, mStatEn, mLy == mLyc, modelMode()});
      readCheck("ly", RegLy, mLy);
      for (int a = 16'hFF40; a <= 16'hFF4B; a++) begin
         if (a != RegLcdc && a != RegStat && a != RegLy && a != RegLyc && a != RegBgp) begin
            readCheck("dropped register", 16'(a), 8'hFF);
         end
      end

      // Two frames of timing with random STAT enables and LYC.
      busWrite(RegStat, 8'(randBits(8)));
      busWrite(RegLyc, 8'(randBits(8) % LinesPerFrame));
      busWrite(RegLcdc, 8'h80 | 8'(randBits(8)));
      idle(FrameCycles);
      busWrite(RegStat, 8'(randBits(8)));
      busWrite(RegLyc, 8'(randBits(8) % LinesPerFrame));
      idle(FrameCycles);

      // CPU VRAM access in VBlank, then lockout in Transfer.
      waitMode(ModeVBlank);
      repeat (8) begin
         addr = VramBase + 16'(randBits(13));
         data = 8'(randBits(8));
         busWrite(addr, data);
         checkValue("vram write", data, vram[addr[12:0]]);
         vramReadCheck("vram read", addr, data);
      end
      waitMode(ModeTransfer);
      addr = VramBase + 16'(randBits(13));
      vramReadCheck("locked read", addr, 8'hFF);
      addr = VramBase + 16'(randBits(13));
      old = vram[addr[12:0]];
      busWrite(addr, ~old);
      checkValue("locked write", old, vram[addr[12:0]]);

      // Random maps, tiles and palette, loaded before each frame.
      repeat (3) begin
         waitMode(ModeVBlank);
         for (int a = 0; a < 8192; a++) vram[a] = 8'(randBits(8));
         busWrite(RegBgp, 8'(randBits(8)));
         busWrite(RegLcdc, 8'h80 | 8'(randBits(8)));
         linesSeen = 0;
         while (modelMode() == ModeVBlank) tick();
         waitMode(ModeVBlank);
         checkValue("lines rendered", VisibleLines, linesSeen);
      end

      $display("TEST PASS");
      $finish;
   end

endmodule

// ==== sources.f ====
hdl/ppuBusPkg.sv
hdl/ppuVideoPkg.sv
hdl/vramIf.sv
hdl/ppuCtrlIf.sv
hdl/cpuBusInterface.sv
hdl/lcdTiming.sv
hdl/bgTileFetcher.sv
hdl/lineComposer.sv
hdl/ppuTop.sv
verification/tbPpu.sv

// ==== Bender.yml ====
package:
  name: ppu_bg_renderer

sources:
  - hdl/ppuBusPkg.sv
  - hdl/ppuVideoPkg.sv
  - hdl/vramIf.sv
  - hdl/ppuCtrlIf.sv
  - hdl/cpuBusInterface.sv
  - hdl/lcdTiming.sv
  - hdl/bgTileFetcher.sv
  - hdl/lineComposer.sv
  - hdl/ppuTop.sv
  - target: test
    files:
      - verification/tbPpu.sv
